// File: rtl/dcache_defs.svh
// data cache miss unit parameters
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// address split, tag | line index | byte offset
`define PADDR_W   16
`define OFFSET_W  4
`define INDEX_W   8
`define CL_IDX_W  4
`define NUM_LINES 16
`define TAG_W     8

// set associativity
`define NUM_WAYS  4
`define WAY_IDX_W 2

// payload widths
`define LINE_W    128
`define DATA_W    32
`define ID_W      2

// port 0 reads, port 1 writes
`define NUM_PORTS 2

// write buffer entries that can still be in flight
`define MAX_TX    2

`endif

// File: rtl/dcache_mem_pkg.sv
// memory side types
package dcache_mem_pkg;

  ////////////////////////////////
  // request kinds
  ////////////////////////////////

  // reads fetch a whole line, stores carry one word
  typedef enum logic [1:0] {
    LOAD_REQ  = 2'd0,
    STORE_REQ = 2'd1
  } mem_req_e;

  ////////////////////////////////
  // return kinds
  ////////////////////////////////

  // one return per request, NONE_ACK is ignored
  typedef enum logic [1:0] {
    LOAD_ACK  = 2'd0,
    STORE_ACK = 2'd1,
    NONE_ACK  = 2'd2
  } mem_rtrn_e;

endpackage

// File: rtl/dcache_ctrl_pkg.sv
// miss controller types
package dcache_ctrl_pkg;

  // controller FSM states
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    DRAIN      = 3'd1,
    FLUSH      = 3'd2,
    STORE_WAIT = 3'd3,
    LOAD_WAIT  = 3'd4
  } miss_state_e;

endpackage

// File: rtl/dcache_mshr.sv
// read miss status register
`include "dcache_defs.svh"

module dcache_mshr (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                mshr_alloc_i,
  input  logic                                load_ack_i,
  input  logic [`PADDR_W-1:0]                 rd_paddr_i,
  input  logic                                rd_nc_i,
  input  logic [`ID_W-1:0]                    rd_id_i,
  input  logic [`NUM_WAYS-1:0]                rd_vld_bits_i,
  input  logic [`PADDR_W-1:0]                 wr_paddr_i,
  input  logic [`MAX_TX-1:0][`PADDR_W-1:0]    tx_paddr_i,
  input  logic [`MAX_TX-1:0]                  tx_vld_i,
  output logic                                mshr_vld_o,
  output logic [`PADDR_W-1:0]                 mshr_paddr_o,
  output logic                                mshr_nc_o,
  output logic [`WAY_IDX_W-1:0]               mshr_way_o,
  output logic [`WAY_IDX_W-1:0]               repl_way_o,
  output logic                                all_ways_valid_o,
  output logic                                rdwr_collision_o,
  output logic                                tx_collision_o
);

  // entry layout, paddr | nc | id | way
  localparam int ENTRY_W = `PADDR_W + 1 + `ID_W + `WAY_IDX_W;
  localparam int LINE_LSB = `OFFSET_W;

  logic [ENTRY_W-1:0]   entry_q;
  logic                 vld_q;
  logic [3:0]           lfsr_q;
  logic [`WAY_IDX_W-1:0] inv_way;
  logic                 all_valid;

  ////////////////////////////////
  // replacement way
  ////////////////////////////////

  // lowest way whose valid bit is clear
  always_comb begin
    inv_way = '0;
    for (int w = `NUM_WAYS - 1; w >= 0; w--) begin
      if (!rd_vld_bits_i[w]) begin
        inv_way = w[`WAY_IDX_W-1:0];
      end
    end
  end

  assign all_valid        = &rd_vld_bits_i;
  assign all_ways_valid_o = all_valid;
  // pseudo random victim once the set is full
  assign repl_way_o       = all_valid ? lfsr_q[`WAY_IDX_W-1:0] : inv_way;

  // x^4 + x^3 + 1, never reaches zero from a nonzero seed
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q <= 4'b0001;
    end else if (mshr_alloc_i && all_valid) begin
      lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
    end
  end

  ////////////////////////////////
  // outstanding read
  ////////////////////////////////

  // only one read in flight, so any load return frees it
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vld_q <= 1'b0;
    end else if (mshr_alloc_i) begin
      vld_q <= 1'b1;
    end else if (load_ack_i) begin
      vld_q <= 1'b0;
    end
  end

  // payload, captured with the chosen way
  always_ff @(posedge clk_i) begin
    if (mshr_alloc_i) begin
      entry_q <= {rd_paddr_i, rd_nc_i, rd_id_i, repl_way_o};
    end
  end

  assign mshr_vld_o   = vld_q;
  assign mshr_paddr_o = entry_q[ENTRY_W-1 -: `PADDR_W];
  assign mshr_nc_o    = entry_q[`ID_W + `WAY_IDX_W];
  assign mshr_way_o   = entry_q[`WAY_IDX_W-1:0];

  ////////////////////////////////
  // line address collisions
  ////////////////////////////////

  // write to the line that is being refilled
  assign rdwr_collision_o = vld_q &&
    (wr_paddr_i[`PADDR_W-1:LINE_LSB] == mshr_paddr_o[`PADDR_W-1:LINE_LSB]);

  // read of a line with a store still in the write buffer
  always_comb begin
    tx_collision_o = 1'b0;
    for (int k = 0; k < `MAX_TX; k++) begin
      if (tx_vld_i[k] &&
          (rd_paddr_i[`PADDR_W-1:LINE_LSB] == tx_paddr_i[k][`PADDR_W-1:LINE_LSB])) begin
        tx_collision_o = 1'b1;
      end
    end
  end

endmodule

// File: rtl/dcache_rtrn_decode.sv
// memory return decoder
`include "dcache_defs.svh"

module dcache_rtrn_decode import dcache_mem_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   mem_rtrn_vld_i,
  input  mem_rtrn_e              mem_rtrn_type_i,
  input  logic [`ID_W-1:0]       mem_rtrn_tid_i,
  input  logic                   mshr_vld_i,
  input  logic                   store_sent_i,
  output logic                   load_ack_o,
  output logic                   store_ack_o,
  output logic [`NUM_PORTS-1:0]  miss_rtrn_vld_o,
  output logic [`ID_W-1:0]       miss_rtrn_id_o
);

  // counter must hold MAX_TX
  localparam int CNT_W = $clog2(`MAX_TX + 1);

  logic [CNT_W-1:0] inflight_q;
  logic             load_ack;
  logic             store_ack;

  ////////////////////////////////
  // decode
  ////////////////////////////////

  // drop returns that nothing is waiting for
  always_comb begin
    load_ack  = 1'b0;
    store_ack = 1'b0;
    if (mem_rtrn_vld_i) begin
      case (mem_rtrn_type_i)
        LOAD_ACK:  load_ack  = mshr_vld_i;
        STORE_ACK: store_ack = (inflight_q != '0);
        default: begin
        end
      endcase
    end
  end

  assign load_ack_o  = load_ack;
  assign store_ack_o = store_ack;

  // read port gets the refill, write port the store ack
  assign miss_rtrn_vld_o = {store_ack, load_ack};
  assign miss_rtrn_id_o  = mem_rtrn_tid_i;

  ////////////////////////////////
  // stores in flight
  ////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      inflight_q <= '0;
    end else if (store_sent_i && !store_ack) begin
      inflight_q <= inflight_q + 1'b1;
    end else if (store_ack && !store_sent_i) begin
      inflight_q <= inflight_q - 1'b1;
    end
  end

endmodule

// File: rtl/dcache_miss_ctrl.sv
// miss controller
`include "dcache_defs.svh"

module dcache_miss_ctrl import dcache_mem_pkg::*; import dcache_ctrl_pkg::*; (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  enable_i,
  input  logic                                  flush_i,
  input  logic                                  wbuffer_empty_i,
  input  logic [`NUM_PORTS-1:0]                 miss_req_i,
  input  logic [`NUM_PORTS-1:0]                 miss_nc_i,
  input  logic [`DATA_W-1:0]                    miss_wdata_i,
  input  logic [`NUM_PORTS-1:0][`PADDR_W-1:0]   miss_paddr_i,
  input  logic [`NUM_PORTS-1:0][`ID_W-1:0]      miss_id_i,
  input  logic                                  mshr_vld_i,
  input  logic [`PADDR_W-1:0]                   mshr_paddr_i,
  input  logic                                  mshr_nc_i,
  input  logic [`WAY_IDX_W-1:0]                 mshr_way_i,
  input  logic [`WAY_IDX_W-1:0]                 repl_way_i,
  input  logic                                  all_ways_valid_i,
  input  logic                                  rdwr_collision_i,
  input  logic                                  tx_collision_i,
  input  logic                                  load_ack_i,
  input  logic                                  mem_data_ack_i,
  input  logic [`LINE_W-1:0]                    mem_rtrn_data_i,
  output logic                                  flush_ack_o,
  output logic                                  miss_o,
  output logic                                  cache_en_o,
  output logic [`NUM_PORTS-1:0]                 miss_ack_o,
  output logic                                  mshr_alloc_o,
  output logic                                  store_sent_o,
  output logic                                  mem_data_req_o,
  output mem_req_e                              mem_rtype_o,
  output logic [`ID_W-1:0]                      mem_tid_o,
  output logic                                  mem_nc_o,
  output logic [`WAY_IDX_W-1:0]                 mem_way_o,
  output logic [`DATA_W-1:0]                    mem_data_o,
  output logic [`PADDR_W-1:0]                   mem_paddr_o,
  output logic                                  wr_cl_vld_o,
  output logic                                  wr_cl_nc_o,
  output logic [`NUM_WAYS-1:0]                  wr_cl_we_o,
  output logic [`TAG_W-1:0]                     wr_cl_tag_o,
  output logic [`CL_IDX_W-1:0]                  wr_cl_idx_o,
  output logic [`LINE_W-1:0]                    wr_cl_data_o,
  output logic [`NUM_WAYS-1:0]                  wr_vld_bits_o
);

  miss_state_e           state_d, state_q;
  logic [`CL_IDX_W-1:0]  cnt_d, cnt_q;
  logic                  enable_d, enable_q;
  logic                  flush_ack_d, flush_ack_q;
  logic                  flush_en, flush_done;
  logic                  sel_wr, rd_req, acked;
  logic                  cl_write_en;
  logic [`NUM_WAYS-1:0]  way_oh;

  ////////////////////////////////
  // port selection
  ////////////////////////////////

  // write port has fixed priority and wait states pin the port
  assign sel_wr = (state_q == LOAD_WAIT)  ? 1'b0 :
                  (state_q == STORE_WAIT) ? 1'b1 : miss_req_i[1];

  // one read at a time
  assign rd_req = miss_req_i[0] && !miss_req_i[1] && !mshr_vld_i;

  assign acked        = mem_data_req_o && mem_data_ack_i;
  assign miss_ack_o   = {acked && sel_wr, acked && !sel_wr};
  assign store_sent_o = acked && (mem_rtype_o == STORE_REQ);
  assign miss_o       = mshr_alloc_o && !miss_nc_i[0];

  ////////////////////////////////
  // memory request fields
  ////////////////////////////////

  assign mem_tid_o   = miss_id_i[sel_wr];
  assign mem_nc_o    = miss_nc_i[sel_wr];
  assign mem_paddr_o = miss_paddr_i[sel_wr];
  assign mem_data_o  = miss_wdata_i;
  // victim way as chosen by the tracker
  assign mem_way_o   = repl_way_i;

  ////////////////////////////////
  // cache line write port
  ////////////////////////////////

  assign way_oh      = {{(`NUM_WAYS-1){1'b0}}, 1'b1} << mshr_way_i;
  // nc refills return data only
  assign cl_write_en = load_ack_i && !mshr_nc_i;

  assign wr_cl_vld_o   = load_ack_i || flush_en;
  assign wr_cl_nc_o    = mshr_nc_i;
  assign wr_cl_we_o    = flush_en ? '1 : (cl_write_en ? way_oh : '0);
  assign wr_vld_bits_o = flush_en ? '0 : (cl_write_en ? way_oh : '0);
  assign wr_cl_idx_o   = flush_en ? cnt_q : mshr_paddr_i[`INDEX_W-1:`OFFSET_W];
  assign wr_cl_tag_o   = mshr_paddr_i[`PADDR_W-1:`INDEX_W];
  assign wr_cl_data_o  = mem_rtrn_data_i;

  // flush walks every line once
  assign cnt_d      = flush_en ? cnt_q + 1'b1 : '0;
  assign flush_done = (cnt_q == `CL_IDX_W'(`NUM_LINES - 1));
  assign cache_en_o = enable_q;

  ////////////////////////////////
  // FSM
  ////////////////////////////////

  always_comb begin
    state_d        = state_q;
    mem_data_req_o = 1'b0;
    mem_rtype_o    = LOAD_REQ;
    mshr_alloc_o   = 1'b0;
    flush_en       = 1'b0;
    flush_ack_o    = 1'b0;
    flush_ack_d    = flush_ack_q;
    // disable at any time but enable only through a flush
    enable_d       = enable_q && enable_i;
    case (state_q)
      IDLE: begin
        if (flush_i || (enable_i && !enable_q)) begin
          if (wbuffer_empty_i && !mshr_vld_i) begin
            flush_ack_d = flush_i;
            state_d     = FLUSH;
          end else begin
            state_d = DRAIN;
          end
        end else if (miss_req_i[1]) begin
          // hold stores to the line under refill
          if (!rdwr_collision_i) begin
            mem_data_req_o = 1'b1;
            mem_rtype_o    = STORE_REQ;
            if (!mem_data_ack_i) begin
              state_d = STORE_WAIT;
            end
          end
        end else if (rd_req && !tx_collision_i) begin
          mem_data_req_o = 1'b1;
          mshr_alloc_o   = mem_data_ack_i;
          if (!mem_data_ack_i) begin
            state_d = LOAD_WAIT;
          end
        end
      end
      STORE_WAIT: begin
        mem_data_req_o = 1'b1;
        mem_rtype_o    = STORE_REQ;
        if (mem_data_ack_i) begin
          state_d = IDLE;
        end
      end
      LOAD_WAIT: begin
        mem_data_req_o = 1'b1;
        if (mem_data_ack_i) begin
          mshr_alloc_o = 1'b1;
          state_d      = IDLE;
        end
      end
      // writes only until buffer and MSHR are empty
      DRAIN: begin
        if (miss_req_i[1] && !rdwr_collision_i) begin
          mem_data_req_o = 1'b1;
          mem_rtype_o    = STORE_REQ;
        end
        // a store that is still waiting for its ack keeps the drain going
        if (wbuffer_empty_i && !mshr_vld_i && !(mem_data_req_o && !mem_data_ack_i)) begin
          state_d = IDLE;
        end
      end
      FLUSH: begin
        flush_en = 1'b1;
        if (flush_done) begin
          state_d     = IDLE;
          flush_ack_o = flush_ack_q;
          flush_ack_d = 1'b0;
          enable_d    = enable_i;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // reset starts with a full flush and the cache off
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= FLUSH;
      cnt_q       <= '0;
      enable_q    <= 1'b0;
      flush_ack_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      cnt_q       <= cnt_d;
      enable_q    <= enable_d;
      flush_ack_q <= flush_ack_d;
    end
  end

endmodule

// File: rtl/dcache_missunit.sv
// data cache miss unit
`include "dcache_defs.svh"

module dcache_missunit import dcache_mem_pkg::*; (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  // cache management
  input  logic                                  enable_i,
  input  logic                                  flush_i,
  output logic                                  flush_ack_o,
  output logic                                  miss_o,
  input  logic                                  wbuffer_empty_i,
  output logic                                  cache_en_o,
  // miss ports, 0 reads and 1 writes
  input  logic [`NUM_PORTS-1:0]                 miss_req_i,
  output logic [`NUM_PORTS-1:0]                 miss_ack_o,
  input  logic [`NUM_PORTS-1:0]                 miss_nc_i,
  input  logic [`DATA_W-1:0]                    miss_wdata_i,
  input  logic [`NUM_PORTS-1:0][`PADDR_W-1:0]   miss_paddr_i,
  input  logic [`NUM_WAYS-1:0]                  miss_vld_bits_i,
  input  logic [`NUM_PORTS-1:0][`ID_W-1:0]      miss_id_i,
  output logic [`NUM_PORTS-1:0]                 miss_rtrn_vld_o,
  output logic [`ID_W-1:0]                      miss_rtrn_id_o,
  // write buffer entries in flight
  input  logic [`MAX_TX-1:0][`PADDR_W-1:0]      tx_paddr_i,
  input  logic [`MAX_TX-1:0]                    tx_vld_i,
  // cache line write port
  output logic                                  wr_cl_vld_o,
  output logic                                  wr_cl_nc_o,
  output logic [`NUM_WAYS-1:0]                  wr_cl_we_o,
  output logic [`TAG_W-1:0]                     wr_cl_tag_o,
  output logic [`CL_IDX_W-1:0]                  wr_cl_idx_o,
  output logic [`LINE_W-1:0]                    wr_cl_data_o,
  output logic [`NUM_WAYS-1:0]                  wr_vld_bits_o,
  // memory returns
  input  logic                                  mem_rtrn_vld_i,
  input  mem_rtrn_e                             mem_rtrn_type_i,
  input  logic [`ID_W-1:0]                      mem_rtrn_tid_i,
  input  logic [`LINE_W-1:0]                    mem_rtrn_data_i,
  // memory requests
  output logic                                  mem_data_req_o,
  input  logic                                  mem_data_ack_i,
  output mem_req_e                              mem_rtype_o,
  output logic [`ID_W-1:0]                      mem_tid_o,
  output logic                                  mem_nc_o,
  output logic [`WAY_IDX_W-1:0]                 mem_way_o,
  output logic [`DATA_W-1:0]                    mem_data_o,
  output logic [`PADDR_W-1:0]                   mem_paddr_o
);

  logic                  mshr_vld, mshr_nc, mshr_alloc;
  logic [`PADDR_W-1:0]   mshr_paddr;
  logic [`WAY_IDX_W-1:0] mshr_way, repl_way;
  logic                  all_ways_valid, rdwr_collision, tx_collision;
  logic                  load_ack, store_sent;

  ////////////////////////////////
  // tracker and decoder
  ////////////////////////////////

  dcache_mshr u_mshr (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .mshr_alloc_i     (mshr_alloc),
    .load_ack_i       (load_ack),
    .rd_paddr_i       (miss_paddr_i[0]),
    .rd_nc_i          (miss_nc_i[0]),
    .rd_id_i          (miss_id_i[0]),
    .rd_vld_bits_i    (miss_vld_bits_i),
    .wr_paddr_i       (miss_paddr_i[1]),
    .tx_paddr_i       (tx_paddr_i),
    .tx_vld_i         (tx_vld_i),
    .mshr_vld_o       (mshr_vld),
    .mshr_paddr_o     (mshr_paddr),
    .mshr_nc_o        (mshr_nc),
    .mshr_way_o       (mshr_way),
    .repl_way_o       (repl_way),
    .all_ways_valid_o (all_ways_valid),
    .rdwr_collision_o (rdwr_collision),
    .tx_collision_o   (tx_collision)
  );

  // store acks go straight out on the write port strobe
  dcache_rtrn_decode u_rtrn_decode (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_type_i (mem_rtrn_type_i),
    .mem_rtrn_tid_i  (mem_rtrn_tid_i),
    .mshr_vld_i      (mshr_vld),
    .store_sent_i    (store_sent),
    .load_ack_o      (load_ack),
    .store_ack_o     (),
    .miss_rtrn_vld_o (miss_rtrn_vld_o),
    .miss_rtrn_id_o  (miss_rtrn_id_o)
  );

  ////////////////////////////////
  // controller
  ////////////////////////////////

  dcache_miss_ctrl u_miss_ctrl (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .enable_i         (enable_i),
    .flush_i          (flush_i),
    .wbuffer_empty_i  (wbuffer_empty_i),
    .miss_req_i       (miss_req_i),
    .miss_nc_i        (miss_nc_i),
    .miss_wdata_i     (miss_wdata_i),
    .miss_paddr_i     (miss_paddr_i),
    .miss_id_i        (miss_id_i),
    .mshr_vld_i       (mshr_vld),
    .mshr_paddr_i     (mshr_paddr),
    .mshr_nc_i        (mshr_nc),
    .mshr_way_i       (mshr_way),
    .repl_way_i       (repl_way),
    .all_ways_valid_i (all_ways_valid),
    .rdwr_collision_i (rdwr_collision),
    .tx_collision_i   (tx_collision),
    .load_ack_i       (load_ack),
    .mem_data_ack_i   (mem_data_ack_i),
    .mem_rtrn_data_i  (mem_rtrn_data_i),
    .flush_ack_o      (flush_ack_o),
    .miss_o           (miss_o),
    .cache_en_o       (cache_en_o),
    .miss_ack_o       (miss_ack_o),
    .mshr_alloc_o     (mshr_alloc),
    .store_sent_o     (store_sent),
    .mem_data_req_o   (mem_data_req_o),
    .mem_rtype_o      (mem_rtype_o),
    .mem_tid_o        (mem_tid_o),
    .mem_nc_o         (mem_nc_o),
    .mem_way_o        (mem_way_o),
    .mem_data_o       (mem_data_o),
    .mem_paddr_o      (mem_paddr_o),
    .wr_cl_vld_o      (wr_cl_vld_o),
    .wr_cl_nc_o       (wr_cl_nc_o),
    .wr_cl_we_o       (wr_cl_we_o),
    .wr_cl_tag_o      (wr_cl_tag_o),
    .wr_cl_idx_o      (wr_cl_idx_o),
    .wr_cl_data_o     (wr_cl_data_o),
    .wr_vld_bits_o    (wr_vld_bits_o)
  );

endmodule

// File: bench/tb_dcache_missunit.sv
// data cache miss unit testbench
`include "dcache_defs.svh"

module tb_dcache_missunit import dcache_mem_pkg::*; ();

  localparam int K_ENABLE  = 0;
  localparam int K_READ    = 1;
  localparam int K_WRITE   = 2;
  localparam int K_FLUSH   = 3;
  localparam int K_RAW     = 4;
  localparam int K_FLUSHRD = 5;
  localparam int NUM_ROWS  = 9;
  localparam int TMO       = 60;

  // one operation with its stimulus and expected results
  typedef struct {
    int          kind;
    logic [15:0] addr;
    logic [31:0] data;
    logic [3:0]  vld;
    logic        nc;
    int          delay;
    int          exp_way;
    logic [7:0]  exp_tag;
    logic [3:0]  exp_idx;
    logic [1:0]  exp_rtrn;
  } row_t;

  logic clk_i = 1'b0;
  logic rst_i;
  logic enable_i, flush_i, flush_ack_o, miss_o, wbuffer_empty_i, cache_en_o;
  logic [`NUM_PORTS-1:0] miss_req_i, miss_ack_o, miss_nc_i, miss_rtrn_vld_o;
  logic [`DATA_W-1:0] miss_wdata_i;
  logic [`NUM_PORTS-1:0][`PADDR_W-1:0] miss_paddr_i;
  logic [`NUM_WAYS-1:0] miss_vld_bits_i;
  logic [`NUM_PORTS-1:0][`ID_W-1:0] miss_id_i;
  logic [`ID_W-1:0] miss_rtrn_id_o, mem_rtrn_tid_i, mem_tid_o;
  logic [`MAX_TX-1:0][`PADDR_W-1:0] tx_paddr_i;
  logic [`MAX_TX-1:0] tx_vld_i;
  logic wr_cl_vld_o, wr_cl_nc_o, mem_rtrn_vld_i, mem_data_req_o, mem_data_ack_i, mem_nc_o;
  logic [`NUM_WAYS-1:0] wr_cl_we_o, wr_vld_bits_o;
  logic [`TAG_W-1:0] wr_cl_tag_o;
  logic [`CL_IDX_W-1:0] wr_cl_idx_o;
  logic [`LINE_W-1:0] wr_cl_data_o, mem_rtrn_data_i;
  mem_rtrn_e mem_rtrn_type_i;
  mem_req_e mem_rtype_o;
  logic [`WAY_IDX_W-1:0] mem_way_o;
  logic [`DATA_W-1:0] mem_data_o;
  logic [`PADDR_W-1:0] mem_paddr_o;

  row_t rows [NUM_ROWS];
  int   seed = 5247;
  int   errors = 0;
  int   row_errors;
  int   passed_rows = 0;

  always #5 clk_i = ~clk_i;

  dcache_missunit u_dcache_missunit (.*);

  ////////////////////////////////
  // helpers
  ////////////////////////////////

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // line contents made from the address
  function automatic logic [127:0] line_of(input logic [15:0] addr);
    return {8{addr}};
  endfunction

  // back-pressure delay that is random when the row asks for it
  function automatic int pick_delay(input int d);
    int r;
    if (d >= 0) begin
      return d;
    end
    r = $random(seed);
    if (r < 0) begin
      r = -r;
    end
    return r % 6;
  endfunction

  // serve one memory request on a port and hand back the way it carried
  task automatic handshake(input int port, input mem_req_e typ, input logic [15:0] addr,
                           input logic [31:0] data, input logic nc, input int delay,
                           output logic [1:0] way);
    int n;
    way = '0;
    n = 0;
    #1;
    while (!mem_data_req_o && n < TMO) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (!mem_data_req_o) begin
      $display("timeout waiting for a memory request on port %0d", port);
      errors++;
      return;
    end
    way = mem_way_o;
    for (int i = 0; i <= delay; i++) begin
      // request and fields stay put while ack is low
      check("mem_data_req_o", mem_data_req_o, 1'b1);
      check("mem_rtype_o", mem_rtype_o, typ);
      check("mem_paddr_o", mem_paddr_o, addr);
      check("mem_tid_o", mem_tid_o, miss_id_i[port]);
      check("mem_nc_o", mem_nc_o, nc);
      check("mem_way_o", mem_way_o, way);
      if (typ == STORE_REQ) begin
        check("mem_data_o", mem_data_o, data);
      end
      check("miss_ack_o", miss_ack_o, 2'b00);
      check("miss_o", miss_o, 1'b0);
      @(negedge clk_i);
      if (i == delay) begin
        mem_data_ack_i = 1'b1;
      end
      #1;
    end
    check("miss_ack_o", miss_ack_o, 2'b01 << port);
    check("miss_o", miss_o, (port == 0) && !nc);
    @(negedge clk_i);
    mem_data_ack_i = 1'b0;
    miss_req_i[port] = 1'b0;
    #1;
    check("miss_ack_o", miss_ack_o, 2'b00);
    check("miss_o", miss_o, 1'b0);
  endtask

  // one memory return pulse checked in its own cycle
  task automatic send_return(input mem_rtrn_e typ, input logic [1:0] tid,
                             input logic [15:0] addr, input row_t r, input logic [1:0] way);
    logic [3:0] we;
    @(negedge clk_i);
    mem_rtrn_vld_i  = 1'b1;
    mem_rtrn_type_i = typ;
    mem_rtrn_tid_i  = tid;
    mem_rtrn_data_i = line_of(addr);
    #1;
    check("miss_rtrn_vld_o", miss_rtrn_vld_o, r.exp_rtrn);
    check("miss_rtrn_id_o", miss_rtrn_id_o, tid);
    if (typ == LOAD_ACK) begin
      we = r.nc ? 4'b0000 : (4'b0001 << way);
      check("wr_cl_vld_o", wr_cl_vld_o, 1'b1);
      check("wr_cl_nc_o", wr_cl_nc_o, r.nc);
      check("wr_cl_we_o", wr_cl_we_o, we);
      check("wr_vld_bits_o", wr_vld_bits_o, we);
      check("wr_cl_tag_o", wr_cl_tag_o, r.exp_tag);
      check("wr_cl_idx_o", wr_cl_idx_o, r.exp_idx);
      check("wr_cl_data_o", wr_cl_data_o, line_of(addr));
    end
    @(negedge clk_i);
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_type_i = NONE_ACK;
  endtask

  // wait for the flush walk and check all of its cycles
  task automatic flush_walk(input logic exp_ack, input logic en_off);
    int n;
    n = 0;
    #1;
    while (!(wr_cl_vld_o && wr_cl_we_o == 4'b1111) && n < TMO) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (!(wr_cl_vld_o && wr_cl_we_o == 4'b1111)) begin
      $display("timeout waiting for the flush to start");
      errors++;
      return;
    end
    for (int k = 0; k < `NUM_LINES; k++) begin
      check("wr_cl_we_o", wr_cl_we_o, 4'b1111);
      check("wr_vld_bits_o", wr_vld_bits_o, 4'b0000);
      check("wr_cl_idx_o", wr_cl_idx_o, k[3:0]);
      check("flush_ack_o", flush_ack_o, exp_ack && (k == `NUM_LINES - 1));
      if (en_off) begin
        check("cache_en_o", cache_en_o, 1'b0);
      end
      @(negedge clk_i);
      // the flush request drops once the walk is under way
      flush_i = 1'b0;
      #1;
    end
    check("wr_cl_vld_o", wr_cl_vld_o, 1'b0);
  endtask

  ////////////////////////////////
  // stimulus
  ////////////////////////////////

  initial begin
    logic [1:0] way;
    rows[0] = '{K_ENABLE, 16'h0000, 32'h0, 4'h0, 1'b0, 0, 0, 8'h00, 4'h0, 2'b00};
    rows[1] = '{K_READ, 16'h1230, 32'h0, 4'b0000, 1'b0, 0, 0, 8'h12, 4'h3, 2'b01};
    rows[2] = '{K_READ, 16'h45a0, 32'h0, 4'b0101, 1'b0, -1, 1, 8'h45, 4'ha, 2'b01};
    rows[3] = '{K_READ, 16'h7f10, 32'h0, 4'b1111, 1'b0, -1, -1, 8'h7f, 4'h1, 2'b01};
    rows[4] = '{K_READ, 16'h2340, 32'h0, 4'b0000, 1'b1, 1, 0, 8'h23, 4'h4, 2'b01};
    rows[5] = '{K_WRITE, 16'h5678, 32'hdeadbeef, 4'h0, 1'b0, -1, 0, 8'h00, 4'h0, 2'b10};
    rows[6] = '{K_RAW, 16'h3450, 32'hcafe0001, 4'b0011, 1'b0, 0, 2, 8'h34, 4'h5, 2'b01};
    rows[7] = '{K_FLUSHRD, 16'h6780, 32'h0, 4'b0000, 1'b0, 0, 0, 8'h67, 4'h8, 2'b01};
    rows[8] = '{K_FLUSH, 16'h0000, 32'h0, 4'h0, 1'b0, 0, 0, 8'h00, 4'h0, 2'b00};
    rst_i = 1'b1;
    enable_i = 1'b0;
    flush_i = 1'b0;
    wbuffer_empty_i = 1'b1;
    miss_req_i = '0;
    miss_nc_i = '0;
    miss_wdata_i = '0;
    miss_paddr_i = '0;
    miss_vld_bits_i = '0;
    miss_id_i = {2'd2, 2'd1};
    tx_paddr_i = '0;
    tx_vld_i = '0;
    mem_rtrn_vld_i = 1'b0;
    mem_rtrn_type_i = NONE_ACK;
    mem_rtrn_tid_i = '0;
    mem_rtrn_data_i = '0;
    mem_data_ack_i = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    // reset flush with the cache still off
    check("mem_data_req_o", mem_data_req_o, 1'b0);
    flush_walk(1'b0, 1'b1);
    $display("reset flush %s", errors == 0 ? "ok" : "FAIL");
    for (int i = 0; i < NUM_ROWS; i++) begin
      row_errors = errors;
      @(negedge clk_i);
      miss_vld_bits_i = rows[i].vld;
      miss_nc_i = {1'b0, rows[i].nc};
      case (rows[i].kind)
        K_ENABLE: begin
          enable_i = 1'b1;
          flush_walk(1'b0, 1'b1);
          check("cache_en_o", cache_en_o, 1'b1);
        end
        K_READ, K_RAW, K_FLUSHRD: begin
          miss_paddr_i[0] = rows[i].addr;
          miss_req_i[0] = 1'b1;
          handshake(0, LOAD_REQ, rows[i].addr, 32'h0, rows[i].nc,
                    pick_delay(rows[i].delay), way);
          if (rows[i].exp_way >= 0) begin
            check("mem_way_o", way, rows[i].exp_way[1:0]);
          end
          if (rows[i].kind == K_RAW) begin
            // write to the line under refill is held back
            @(negedge clk_i);
            miss_paddr_i[1] = rows[i].addr + 16'h4;
            miss_wdata_i = rows[i].data;
            miss_req_i[1] = 1'b1;
            repeat (3) begin
              #1;
              check("mem_data_req_o", mem_data_req_o, 1'b0);
              @(negedge clk_i);
            end
          end
          if (rows[i].kind == K_FLUSHRD) begin
            @(negedge clk_i);
            flush_i = 1'b1;
            repeat (3) begin
              #1;
              check("wr_cl_vld_o", wr_cl_vld_o, 1'b0);
              @(negedge clk_i);
            end
          end
          send_return(LOAD_ACK, miss_id_i[0], rows[i].addr, rows[i], way);
          if (rows[i].kind == K_RAW) begin
            handshake(1, STORE_REQ, rows[i].addr + 16'h4, rows[i].data, 1'b0, 0, way);
            rows[i].exp_rtrn = 2'b10;
            send_return(STORE_ACK, miss_id_i[1], rows[i].addr, rows[i], way);
          end
          if (rows[i].kind == K_FLUSHRD) begin
            flush_walk(1'b1, 1'b0);
          end
        end
        K_WRITE: begin
          miss_paddr_i[1] = rows[i].addr;
          miss_wdata_i = rows[i].data;
          miss_req_i[1] = 1'b1;
          handshake(1, STORE_REQ, rows[i].addr, rows[i].data, 1'b0,
                    pick_delay(rows[i].delay), way);
          send_return(STORE_ACK, miss_id_i[1], rows[i].addr, rows[i], way);
        end
        default: begin
          flush_i = 1'b1;
          flush_walk(1'b1, 1'b0);
        end
      endcase
      if (errors == row_errors) begin
        passed_rows++;
        $display("row %0d ok", i);
      end else begin
        $display("row %0d FAIL", i);
      end
    end
    $display("rows passed %0d of %0d, errors %0d", passed_rows, NUM_ROWS, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+rtl
rtl/dcache_mem_pkg.sv
rtl/dcache_ctrl_pkg.sv
rtl/dcache_mshr.sv
rtl/dcache_rtrn_decode.sv
rtl/dcache_miss_ctrl.sv
rtl/dcache_missunit.sv
bench/tb_dcache_missunit.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary -j 0
TOP       = tb_dcache_missunit
FILELIST  = compile.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
